// ==== verilog.f ====
+incdir+test
design/cache_pkg.sv
design/way_if.sv
design/cache_way.sv
design/way_select.sv
design/mesi_ctrl.sv
design/four_way_cache.sv
test/cache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cache testbench with Verilator 5 (timing support needed)
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary -Wno-fatal --top-module cache_tb -f verilog.f -Mdir obj_dir
./obj_dir/Vcache_tb | tee sim.log

if grep -q "TB FAILED" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
echo "simulation clean"

// ==== test/cache_tb_tasks.svh ====
// directed tests and compare task included inside cache_tb; literals assume the default geometry
`ifndef cache_tb_tasks_svh
`define cache_tb_tasks_svh

////////////////////////////////////////
// compare

task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
	check_count++;
	if (got !== want) begin
		err_count++;
		$display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, want);
	end
endtask

////////////////////////////////////////
// directed tests

// cold miss from memory then a hit and a clean snoop
task automatic cold_read_miss();
	logic [31:0] a;
	a = make_addr(26'h0a1, 4'd1, 2'd2);
	cpu_access(1'b0, a, 8'h00, 32'h4433_2211, 32'hdead_beef, 1'b0);
	check("miss", 32'(miss), 1);
	check("bus_rd", 32'(bus_rd), 1);
	check("rd_data", 32'(rd_data), 32'h33); // byte from memory rather than the shared line
	cpu_access(1'b0, make_addr(26'h0a1, 4'd1, 2'd0), 8'h00, 32'hffff_ffff,
		32'hffff_ffff, 1'b0);
	check("hit", 32'(hit), 1);
	check("rd_data", 32'(rd_data), 32'h11); // stored line wins over the fill inputs
	snoop_probe(1'b0, a);
	check("snoop_hit", 32'(snoop_hit), 1);
	check("snoop_dirty", 32'(snoop_dirty), 0); // still E before the snoop
endtask

// fill from another cache in S and a write that upgrades
task automatic shared_fill_upgrade();
	logic [31:0] b;
	b = make_addr(26'h0b2, 4'd2, 2'd1);
	cpu_access(1'b0, b, 8'h00, 32'h0102_0304, 32'ha1b2_c3d4, 1'b1);
	check("miss", 32'(miss), 1);
	check("rd_data", 32'(rd_data), 32'hc3);
	cpu_access(1'b1, b, 8'h5a, 32'h0, 32'h0, 1'b0);
	check("hit", 32'(hit), 1);
	check("bus_upgr", 32'(bus_upgr), 1);
	check("bus_rdx", 32'(bus_rdx), 0);
endtask

// silent E to M followed by a dirty and then a clean snoop
task automatic write_hit_dirty_snoop();
	logic [31:0] c;
	c = make_addr(26'h0c3, 4'd3, 2'd0);
	cpu_access(1'b0, c, 8'h00, 32'h1020_3040, 32'h0, 1'b0);
	cpu_access(1'b1, make_addr(26'h0c3, 4'd3, 2'd3), 8'h7e, 32'h0, 32'h0, 1'b0);
	check("hit", 32'(hit), 1);
	check("bus_rd", 32'(bus_rd), 0);
	check("bus_rdx", 32'(bus_rdx), 0);
	check("bus_upgr", 32'(bus_upgr), 0); // E needs no bus
	snoop_probe(1'b0, c);
	check("snoop_dirty", 32'(snoop_dirty), 1);
	check("snoop_line", 32'(snoop_line), 32'h7e20_3040);
	snoop_probe(1'b0, c);
	check("snoop_hit", 32'(snoop_hit), 1);
	check("snoop_dirty", 32'(snoop_dirty), 0); // now S
endtask

// busRdX drops the line and an absent tag misses the snoop
task automatic snoop_invalidate();
	logic [31:0] d;
	d = make_addr(26'h0d4, 4'd4, 2'd0);
	cpu_access(1'b0, d, 8'h00, 32'h5555_aaaa, 32'h0, 1'b0);
	snoop_probe(1'b1, d);
	check("snoop_hit", 32'(snoop_hit), 1);
	cpu_access(1'b0, d, 8'h00, 32'h6666_bbbb, 32'h0, 1'b0);
	check("miss", 32'(miss), 1);
	snoop_probe(1'b0, make_addr(26'h155_5555, 4'd4, 2'd0));
	check("snoop_hit", 32'(snoop_hit), 0);
endtask

// fifth tag in a full set pushes out dirty way 0
task automatic round_robin_evict();
	cpu_access(1'b0, make_addr(26'h100, 4'd7, 2'd0), 8'h00, 32'h0000_1000, 32'h0, 1'b0);
	cpu_access(1'b1, make_addr(26'h100, 4'd7, 2'd0), 8'hab, 32'h0, 32'h0, 1'b0);
	cpu_access(1'b0, make_addr(26'h101, 4'd7, 2'd1), 8'h00, 32'h0000_1010, 32'h0, 1'b0);
	cpu_access(1'b1, make_addr(26'h102, 4'd7, 2'd2), 8'hcd, 32'h0000_1020, 32'h0, 1'b0);
	cpu_access(1'b0, make_addr(26'h103, 4'd7, 2'd3), 8'h00, 32'h0000_1030, 32'h0, 1'b1);
	cpu_access(1'b0, make_addr(26'h104, 4'd7, 2'd0), 8'h00, 32'h0000_1040, 32'h0, 1'b0);
	check("evict_valid", 32'(evict_valid), 1);
	check("evict_addr", evict_addr, make_addr(26'h100, 4'd7, 2'd0));
	check("evict_line", 32'(evict_line), 32'h0000_10ab);
	// pointer now at way 1 which is clean
	cpu_access(1'b0, make_addr(26'h105, 4'd7, 2'd0), 8'h00, 32'h0000_1050, 32'h0, 1'b0);
	check("evict_valid", 32'(evict_valid), 0);
	// tag 101 sat in way 1 and must be gone
	cpu_access(1'b0, make_addr(26'h101, 4'd7, 2'd1), 8'h00, 32'h0000_1060, 32'h0, 1'b0);
	check("miss", 32'(miss), 1);
endtask

// 8 tags over sets 12 and 13 checked against the model
task automatic random_traffic();
	logic [31:0] tg_r;
	logic [31:0] set_r;
	logic [31:0] off_r;
	logic [31:0] we_r;
	logic [31:0] wdata_r;
	logic [31:0] mem_r;
	logic [31:0] sh_r;
	logic [31:0] shared_r;
	for (int n = 0; n < random_ops; n++) begin
		random_bits(3, tg_r);
		random_bits(1, set_r);
		random_bits(2, off_r);
		random_bits(1, we_r);
		random_bits(8, wdata_r);
		random_bits(32, mem_r);
		random_bits(32, sh_r);
		random_bits(1, shared_r);
		cpu_access(we_r[0],
			make_addr(26'h200 + 26'(tg_r[2:0]), set_r[0] ? 4'd12 : 4'd13, off_r[1:0]),
			wdata_r[7:0], mem_r, sh_r, shared_r[0]);
	end
endtask

`endif

// ==== test/cache_tb.sv ====
// cache testbench with its own line model; assumes 32-bit addresses and lines, one request per cycle
`default_nettype none

module cache_tb;

	localparam int set_w       = 4;
	localparam int off_w       = 2;
	localparam int tag_w       = cache_pkg::addr_w - set_w - off_w;
	localparam int line_w      = cache_pkg::byte_w * (2 ** off_w);
	localparam int sets        = 2 ** set_w;
	localparam int period      = 8;
	localparam int random_ops  = 200;
	localparam int test_cycles = 8 + 30 + random_ops; // reset, directed, random
	localparam int margin      = 40 * period;

	logic                         clk;
	logic                         rst_n;
	logic                         cpu_req;
	logic                         cpu_we;
	logic [cache_pkg::addr_w-1:0] cpu_addr;
	logic [cache_pkg::byte_w-1:0] cpu_wdata;
	logic [line_w-1:0]            mem_line_in;
	logic [line_w-1:0]            shared_line_in;
	logic                         shared_in;
	logic                         snoop_valid;
	logic                         snoop_rdx;
	logic [cache_pkg::addr_w-1:0] snoop_addr;
	logic                         rsp_valid;
	logic                         hit;
	logic                         miss;
	logic [cache_pkg::byte_w-1:0] rd_data;
	logic                         bus_rd;
	logic                         bus_rdx;
	logic                         bus_upgr;
	logic                         evict_valid;
	logic [cache_pkg::addr_w-1:0] evict_addr;
	logic [line_w-1:0]            evict_line;
	logic                         snoop_hit;
	logic                         snoop_dirty;
	logic [line_w-1:0]            snoop_line;

	// model of the four ways
	logic [cache_pkg::mesi_w-1:0] m_state [4][sets];
	logic [tag_w-1:0]             m_tag   [4][sets];
	logic [line_w-1:0]            m_line  [4][sets];
	logic [1:0]                   m_ptr;              // one pointer for every set

	int          err_count;
	int          check_count;
	logic [15:0] lfsr_q;

	////////////////////////////////////////
	// clock and DUT

	always #(period / 2) clk = ~clk;

	four_way_cache #(.set_w(set_w), .off_w(off_w)) i_four_way_cache (.*);

	////////////////////////////////////////
	// random source

	// fibonacci, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// one lfsr step per bit taken
	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
	endtask

	////////////////////////////////////////
	// model helpers

	function automatic logic [31:0] make_addr(input logic [tag_w-1:0] tg,
			input logic [set_w-1:0] st, input logic [off_w-1:0] off);
		return {tg, st, off};
	endfunction

	// way holding the tag, -1 when absent
	function automatic int lookup_way(input logic [tag_w-1:0] tg, input logic [set_w-1:0] st);
		int found;
		found = -1;
		for (int w = 0; w < 4; w++) begin
			if (m_state[w][st] != cache_pkg::st_i && m_tag[w][st] == tg) found = w;
		end
		return found;
	endfunction

	// lowest invalid way, else the pointer
	function automatic int pick_victim(input logic [set_w-1:0] st);
		int v;
		v = int'(m_ptr);
		for (int w = 3; w >= 0; w--) begin
			if (m_state[w][st] == cache_pkg::st_i) v = w;
		end
		return v;
	endfunction

	// one cpu request, checked in its rsp_valid cycle
	task automatic cpu_access(input logic we, input logic [31:0] addr, input logic [7:0] wdata,
			input logic [line_w-1:0] mem_line, input logic [line_w-1:0] sh_line,
			input logic shared);
		logic [tag_w-1:0]             tg;
		logic [set_w-1:0]             st;
		int                           bo;
		int                           way;
		logic                         was_hit;
		logic [cache_pkg::mesi_w-1:0] old_state;
		logic [line_w-1:0]            line;
		logic                         ev;
		logic [31:0]                  ev_addr;
		logic [line_w-1:0]            ev_line;
		tg = addr[cache_pkg::addr_w-1 -: tag_w];
		st = addr[off_w +: set_w];
		bo = int'(addr[off_w-1:0]) * cache_pkg::byte_w;
		way = lookup_way(tg, st);
		was_hit = (way >= 0);
		if (!was_hit) way = pick_victim(st);
		old_state = m_state[way][st];
		ev = !was_hit && (old_state == cache_pkg::st_m); // only a dirty victim leaves
		ev_addr = {m_tag[way][st], st, {off_w{1'b0}}};
		ev_line = m_line[way][st];
		if (was_hit) line = m_line[way][st];
		else if (we) line = mem_line;            // ownership read from memory
		else line = shared ? sh_line : mem_line;
		if (we) line[bo +: 8] = wdata;
		cpu_req = 1'b1;
		cpu_we = we;
		cpu_addr = addr;
		cpu_wdata = wdata;
		mem_line_in = mem_line;
		shared_line_in = sh_line;
		shared_in = shared;
		@(posedge clk);
		#1;
		cpu_req = 1'b0;
		cpu_we = 1'b0;
		check("rsp_valid", 32'(rsp_valid), 1);
		check("hit", 32'(hit), 32'(was_hit));
		check("miss", 32'(miss), 32'(!was_hit));
		check("rd_data", 32'(rd_data), 32'(line[bo +: 8]));
		check("bus_rd", 32'(bus_rd), 32'(!was_hit && !we));
		check("bus_rdx", 32'(bus_rdx), 32'(!was_hit && we));
		check("bus_upgr", 32'(bus_upgr), 32'(was_hit && we && old_state == cache_pkg::st_s));
		check("evict_valid", 32'(evict_valid), 32'(ev));
		if (ev) begin
			check("evict_addr", evict_addr, ev_addr);
			check("evict_line", 32'(evict_line), 32'(ev_line));
		end
		// model update
		if (!was_hit && old_state != cache_pkg::st_i) m_ptr = m_ptr + 2'd1; // full set
		if (we) m_state[way][st] = cache_pkg::st_m;
		else if (!was_hit) m_state[way][st] = shared ? cache_pkg::st_s : cache_pkg::st_e;
		m_tag[way][st] = tg;
		m_line[way][st] = line;
	endtask

	// one snoop, checked the cycle after
	task automatic snoop_probe(input logic rdx, input logic [31:0] addr);
		logic [set_w-1:0] st;
		int               way;
		st = addr[off_w +: set_w];
		way = lookup_way(addr[cache_pkg::addr_w-1 -: tag_w], st);
		snoop_valid = 1'b1;
		snoop_rdx = rdx;
		snoop_addr = addr;
		@(posedge clk);
		#1;
		snoop_valid = 1'b0;
		snoop_rdx = 1'b0;
		check("rsp_valid", 32'(rsp_valid), 0); // snoops give no cpu response
		check("snoop_hit", 32'(snoop_hit), 32'(way >= 0));
		if (way >= 0) begin
			check("snoop_dirty", 32'(snoop_dirty), 32'(m_state[way][st] == cache_pkg::st_m));
			check("snoop_line", 32'(snoop_line), 32'(m_line[way][st]));
			m_state[way][st] = rdx ? cache_pkg::st_i : cache_pkg::st_s;
		end else begin
			check("snoop_dirty", 32'(snoop_dirty), 0);
		end
	endtask

	////////////////////////////////////////
	// main sequence

	initial begin
		err_count = 0;
		check_count = 0;
		lfsr_q = 16'd38;
		clk = 1'b0;
		rst_n = 1'b0;
		cpu_req = 1'b0;
		cpu_we = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		mem_line_in = '0;
		shared_line_in = '0;
		shared_in = 1'b0;
		snoop_valid = 1'b0;
		snoop_rdx = 1'b0;
		snoop_addr = '0;
		m_ptr = 2'd0;
		for (int w = 0; w < 4; w++) begin
			for (int s = 0; s < sets; s++) begin
				m_state[w][s] = cache_pkg::st_i;
				m_tag[w][s] = '0;
				m_line[w][s] = '0;
			end
		end
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		cold_read_miss();
		shared_fill_upgrade();
		write_hit_dirty_snoop();
		snoop_invalidate();
		round_robin_evict();
		random_traffic();
		$display("closing report: %0d checks, %0d errors", check_count, err_count);
		if (err_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(test_cycles * period + margin);
		$display("watchdog: tests still running after %0d time units", test_cycles * period + margin);
		$display("TB FAILED");
		$finish;
	end

	`include "cache_tb_tasks.svh"

endmodule

`default_nettype wire

// ==== design/four_way_cache.sv ====
// four-way MESI data cache top; one cycle per request, no handshake, snoop beats a cpu request
`default_nettype none

module four_way_cache #(
	parameter int set_w = 4, // 16 sets
	parameter int off_w = 2, // 4-byte lines
	localparam int tag_w = cache_pkg::addr_w - set_w - off_w,
	localparam int line_w = cache_pkg::byte_w * (2 ** off_w)
) (
	input  logic                         clk,
	input  logic                         rst_n,
	// cpu
	input  logic                         cpu_req,
	input  logic                         cpu_we,
	input  logic [cache_pkg::addr_w-1:0] cpu_addr,
	input  logic [cache_pkg::byte_w-1:0] cpu_wdata,
	// fill sources
	input  logic [line_w-1:0]            mem_line_in,
	input  logic [line_w-1:0]            shared_line_in,
	input  logic                         shared_in,
	// snoop
	input  logic                         snoop_valid,
	input  logic                         snoop_rdx,
	input  logic [cache_pkg::addr_w-1:0] snoop_addr,
	// responses
	output logic                         rsp_valid,
	output logic                         hit,
	output logic                         miss,
	output logic [cache_pkg::byte_w-1:0] rd_data,
	output logic                         bus_rd,
	output logic                         bus_rdx,
	output logic                         bus_upgr,
	output logic                         evict_valid,
	output logic [cache_pkg::addr_w-1:0] evict_addr,
	output logic [line_w-1:0]            evict_line,
	output logic                         snoop_hit,
	output logic                         snoop_dirty,
	output logic [line_w-1:0]            snoop_line
);

	logic [cache_pkg::addr_w-1:0] lk_addr;
	logic [tag_w-1:0]             lookup_tag;
	logic [set_w-1:0]             set_idx;
	logic [off_w-1:0]             offset;

	logic                         any_hit;
	logic [1:0]                   hit_way;
	logic [cache_pkg::mesi_w-1:0] sel_state;
	logic [line_w-1:0]            sel_line;
	logic [1:0]                   victim_way;
	logic [cache_pkg::mesi_w-1:0] victim_state;
	logic [tag_w-1:0]             victim_tag;
	logic [line_w-1:0]            victim_line;
	logic                         adv;

	////////////////////////////////////////
	// address split, snoop steals the lookup

	assign lk_addr = snoop_valid ? snoop_addr : cpu_addr;
	assign {lookup_tag, set_idx, offset} = lk_addr;

	////////////////////////////////////////
	// ways

	way_if #(.set_w(set_w), .off_w(off_w)) wif [4] ();

	for (genvar i = 0; i < 4; i++) begin : g_way
		cache_way #(.set_w(set_w), .off_w(off_w)) i_cache_way (
			.clk        (clk),
			.rst_n      (rst_n),
			.set_idx    (set_idx),
			.lookup_tag (lookup_tag),
			.w          (wif[i])
		);
	end

	// encoder, muxes, victim pointer
	way_select #(.set_w(set_w), .off_w(off_w)) i_way_select (
		.clk          (clk),
		.rst_n        (rst_n),
		.adv          (adv),
		.w0           (wif[0]),
		.w1           (wif[1]),
		.w2           (wif[2]),
		.w3           (wif[3]),
		.any_hit      (any_hit),
		.hit_way      (hit_way),
		.sel_state    (sel_state),
		.sel_line     (sel_line),
		.victim_way   (victim_way),
		.victim_state (victim_state),
		.victim_tag   (victim_tag),
		.victim_line  (victim_line)
	);

	// behavior
	mesi_ctrl #(.set_w(set_w), .off_w(off_w)) i_mesi_ctrl (
		.clk            (clk),
		.rst_n          (rst_n),
		.cpu_req        (cpu_req),
		.cpu_we         (cpu_we),
		.cpu_wdata      (cpu_wdata),
		.offset         (offset),
		.set_idx        (set_idx),
		.lookup_tag     (lookup_tag),
		.mem_line_in    (mem_line_in),
		.shared_line_in (shared_line_in),
		.shared_in      (shared_in),
		.snoop_valid    (snoop_valid),
		.snoop_rdx      (snoop_rdx),
		.any_hit        (any_hit),
		.hit_way        (hit_way),
		.sel_state      (sel_state),
		.sel_line       (sel_line),
		.victim_way     (victim_way),
		.victim_state   (victim_state),
		.victim_tag     (victim_tag),
		.victim_line    (victim_line),
		.w0             (wif[0]),
		.w1             (wif[1]),
		.w2             (wif[2]),
		.w3             (wif[3]),
		.adv            (adv),
		.rsp_valid      (rsp_valid),
		.hit            (hit),
		.miss           (miss),
		.rd_data        (rd_data),
		.bus_rd         (bus_rd),
		.bus_rdx        (bus_rdx),
		.bus_upgr       (bus_upgr),
		.evict_valid    (evict_valid),
		.evict_addr     (evict_addr),
		.evict_line     (evict_line),
		.snoop_hit      (snoop_hit),
		.snoop_dirty    (snoop_dirty),
		.snoop_line     (snoop_line)
	);

endmodule

`default_nettype wire

// ==== design/mesi_ctrl.sv ====
// MESI behavior; fill lines must be valid with the request, a snoop in the same cycle drops the cpu request
`default_nettype none

module mesi_ctrl #(
	parameter int set_w = 4,
	parameter int off_w = 2,
	localparam int tag_w = cache_pkg::addr_w - set_w - off_w,
	localparam int line_w = cache_pkg::byte_w * (2 ** off_w)
) (
	input  logic                          clk,
	input  logic                          rst_n,
	// cpu side
	input  logic                          cpu_req,
	input  logic                          cpu_we,
	input  logic [cache_pkg::byte_w-1:0]  cpu_wdata,
	input  logic [off_w-1:0]              offset,
	input  logic [set_w-1:0]              set_idx,
	input  logic [tag_w-1:0]              lookup_tag,
	// fill sources and snoop
	input  logic [line_w-1:0]             mem_line_in,
	input  logic [line_w-1:0]             shared_line_in,
	input  logic                          shared_in,
	input  logic                          snoop_valid,
	input  logic                          snoop_rdx,
	// from the way selector
	input  logic                          any_hit,
	input  logic [1:0]                    hit_way,
	input  logic [cache_pkg::mesi_w-1:0]  sel_state,
	input  logic [line_w-1:0]             sel_line,
	input  logic [1:0]                    victim_way,
	input  logic [cache_pkg::mesi_w-1:0]  victim_state,
	input  logic [tag_w-1:0]              victim_tag,
	input  logic [line_w-1:0]             victim_line,
	way_if.ctrl                           w0,
	way_if.ctrl                           w1,
	way_if.ctrl                           w2,
	way_if.ctrl                           w3,
	output logic                          adv,
	// registered responses
	output logic                          rsp_valid,
	output logic                          hit,
	output logic                          miss,
	output logic [cache_pkg::byte_w-1:0]  rd_data,
	output logic                          bus_rd,
	output logic                          bus_rdx,
	output logic                          bus_upgr,
	output logic                          evict_valid,
	output logic [cache_pkg::addr_w-1:0]  evict_addr,
	output logic [line_w-1:0]             evict_line,
	output logic                          snoop_hit,
	output logic                          snoop_dirty,
	output logic [line_w-1:0]             snoop_line
);

	logic                         do_cpu;    // cpu request that survives a snoop
	logic                         wr_any;
	logic                         fill;
	logic [1:0]                   tgt_way;
	logic [cache_pkg::mesi_w-1:0] nstate;
	logic [line_w-1:0]            base_line;
	logic [line_w-1:0]            nline;
	logic [cache_pkg::byte_w-1:0] rd_byte;

	assign do_cpu = cpu_req && !snoop_valid;

	////////////////////////////////////////
	// next state and line

	always_comb begin
		wr_any  = 1'b0;
		fill    = 1'b0;
		tgt_way = hit_way;
		nstate  = sel_state;
		// hit keeps its own data, a miss picks its fill source
		if (any_hit) base_line = sel_line;
		else if (shared_in && !cpu_we) base_line = shared_line_in;
		else base_line = mem_line_in;
		nline = base_line;

		if (snoop_valid) begin
			if (any_hit) begin
				wr_any = 1'b1;
				// busRdX kills the copy, busRd demotes M and E to S
				nstate = snoop_rdx ? cache_pkg::st_i : cache_pkg::st_s;
			end
		end else if (cpu_req) begin
			if (cpu_we) begin
				nline[offset * cache_pkg::byte_w +: cache_pkg::byte_w] = cpu_wdata;
				nstate = cache_pkg::st_m; // silent from E or M
				wr_any = 1'b1;
			end else if (!any_hit) begin
				nstate = shared_in ? cache_pkg::st_s : cache_pkg::st_e;
				wr_any = 1'b1;
			end
			if (!any_hit) begin
				fill    = 1'b1;
				tgt_way = victim_way;
			end
		end
	end

	// read byte after the merge, so a write echoes its own data
	assign rd_byte = nline[offset * cache_pkg::byte_w +: cache_pkg::byte_w];

	assign adv = fill;

	////////////////////////////////////////
	// way write ports

	assign w0.wr_en    = wr_any && (tgt_way == 2'd0);
	assign w0.wr_state = nstate;
	assign w0.wr_tag   = lookup_tag;
	assign w0.wr_line  = nline;

	assign w1.wr_en    = wr_any && (tgt_way == 2'd1);
	assign w1.wr_state = nstate;
	assign w1.wr_tag   = lookup_tag;
	assign w1.wr_line  = nline;

	assign w2.wr_en    = wr_any && (tgt_way == 2'd2);
	assign w2.wr_state = nstate;
	assign w2.wr_tag   = lookup_tag;
	assign w2.wr_line  = nline;

	assign w3.wr_en    = wr_any && (tgt_way == 2'd3);
	assign w3.wr_state = nstate;
	assign w3.wr_tag   = lookup_tag;
	assign w3.wr_line  = nline;

	////////////////////////////////////////
	// registered responses

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rsp_valid   <= 1'b0;
			hit         <= 1'b0;
			miss        <= 1'b0;
			bus_rd      <= 1'b0;
			bus_rdx     <= 1'b0;
			bus_upgr    <= 1'b0;
			evict_valid <= 1'b0;
			snoop_hit   <= 1'b0;
			snoop_dirty <= 1'b0;
		end else begin
			rsp_valid   <= do_cpu;
			hit         <= do_cpu && any_hit;
			miss        <= do_cpu && !any_hit;
			bus_rd      <= do_cpu && !any_hit && !cpu_we;
			bus_rdx     <= do_cpu && !any_hit && cpu_we;
			bus_upgr    <= do_cpu && any_hit && cpu_we && (sel_state == cache_pkg::st_s);
			evict_valid <= fill && (victim_state == cache_pkg::st_m); // dirty victim only
			snoop_hit   <= snoop_valid && any_hit;
			snoop_dirty <= snoop_valid && any_hit && (sel_state == cache_pkg::st_m);
		end
	end

	// payload, qualified by the strobes above
	always_ff @(posedge clk) begin
		rd_data    <= rd_byte;
		evict_addr <= {victim_tag, set_idx, {off_w{1'b0}}}; // line aligned
		evict_line <= victim_line;
		snoop_line <= sel_line;
	end

endmodule

`default_nettype wire

// ==== design/way_select.sv ====
// hit encoder and way muxes; at most one way may hit, victim is first invalid else round robin
`default_nettype none

module way_select #(
	parameter int set_w = 4,
	parameter int off_w = 2,
	localparam int tag_w = cache_pkg::addr_w - set_w - off_w,
	localparam int line_w = cache_pkg::byte_w * (2 ** off_w)
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         adv,          // a fill happens this edge
	way_if.view                          w0,
	way_if.view                          w1,
	way_if.view                          w2,
	way_if.view                          w3,
	output logic                         any_hit,
	output logic [1:0]                   hit_way,
	output logic [cache_pkg::mesi_w-1:0] sel_state,
	output logic [line_w-1:0]            sel_line,
	output logic [1:0]                   victim_way,
	output logic [cache_pkg::mesi_w-1:0] victim_state,
	output logic [tag_w-1:0]             victim_tag,
	output logic [line_w-1:0]            victim_line
);

	logic [3:0] encode; // way 0 in the msb
	logic [1:0] rr_ptr;
	logic       all_valid;

	////////////////////////////////////////
	// hit encoder and data mux

	assign encode  = {w0.hit, w1.hit, w2.hit, w3.hit};
	assign any_hit = |encode;

	always_comb begin
		case (encode)
			4'b1000: hit_way = 2'd0;
			4'b0100: hit_way = 2'd1;
			4'b0010: hit_way = 2'd2;
			4'b0001: hit_way = 2'd3;
			default: hit_way = 2'd0; // miss, mux output unused
		endcase
	end

	always_comb begin
		case (hit_way)
			2'd0: begin
				sel_state = w0.state;
				sel_line  = w0.line;
			end
			2'd1: begin
				sel_state = w1.state;
				sel_line  = w1.line;
			end
			2'd2: begin
				sel_state = w2.state;
				sel_line  = w2.line;
			end
			default: begin
				sel_state = w3.state;
				sel_line  = w3.line;
			end
		endcase
	end

	////////////////////////////////////////
	// victim choice

	always_comb begin
		all_valid = 1'b0;
		if (w0.state == cache_pkg::st_i) victim_way = 2'd0;
		else if (w1.state == cache_pkg::st_i) victim_way = 2'd1;
		else if (w2.state == cache_pkg::st_i) victim_way = 2'd2;
		else if (w3.state == cache_pkg::st_i) victim_way = 2'd3;
		else begin
			victim_way = rr_ptr; // set is full
			all_valid  = 1'b1;
		end
	end

	always_comb begin
		case (victim_way)
			2'd0: begin
				victim_state = w0.state;
				victim_tag   = w0.tag;
				victim_line  = w0.line;
			end
			2'd1: begin
				victim_state = w1.state;
				victim_tag   = w1.tag;
				victim_line  = w1.line;
			end
			2'd2: begin
				victim_state = w2.state;
				victim_tag   = w2.tag;
				victim_line  = w2.line;
			end
			default: begin
				victim_state = w3.state;
				victim_tag   = w3.tag;
				victim_line  = w3.line;
			end
		endcase
	end

	// one pointer shared by all sets
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rr_ptr <= 2'd0;
		end else if (adv && all_valid) begin
			rr_ptr <= rr_ptr + 2'd1; // wraps 3 to 0
		end
	end

endmodule

`default_nettype wire

// ==== design/cache_way.sv ====
// single way store; lookup is combinational, writes land at the clock edge at set_idx
`default_nettype none

module cache_way #(
	parameter int set_w = 4,
	parameter int off_w = 2,
	localparam int tag_w = cache_pkg::addr_w - set_w - off_w,
	localparam int line_w = cache_pkg::byte_w * (2 ** off_w),
	localparam int sets = 2 ** set_w
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [set_w-1:0] set_idx,    // same index to all four ways
	input  logic [tag_w-1:0] lookup_tag,
	way_if.store             w
);

	////////////////////////////////////////
	// storage

	logic [cache_pkg::mesi_w-1:0] state_mem [sets];
	logic [tag_w-1:0]             tag_mem   [sets];
	logic [line_w-1:0]            line_mem  [sets];

	// state array, every line invalid out of reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < sets; i++) begin
				state_mem[i] <= cache_pkg::st_i;
			end
		end else if (w.wr_en) begin
			state_mem[set_idx] <= w.wr_state;
		end
	end

	// tag and data, only meaningful under a valid state
	always_ff @(posedge clk) begin
		if (w.wr_en) begin
			tag_mem[set_idx]  <= w.wr_tag;
			line_mem[set_idx] <= w.wr_line;
		end
	end

	////////////////////////////////////////
	// lookup

	assign w.state = state_mem[set_idx];
	assign w.tag   = tag_mem[set_idx];
	assign w.line  = line_mem[set_idx];

	// invalid lines never hit, whatever the stale tag says
	assign w.hit = (w.state != cache_pkg::st_i) && (w.tag == lookup_tag);

endmodule

`default_nettype wire

// ==== design/way_if.sv ====
// one way's lookup result and write port; set_w and off_w must match the cache top
`default_nettype none

interface way_if #(
	parameter int set_w = 4,
	parameter int off_w = 2
);

	localparam int tag_w  = cache_pkg::addr_w - set_w - off_w;
	localparam int line_w = cache_pkg::byte_w * (2 ** off_w);

	// lookup side, driven by the way
	logic                        hit;
	logic [cache_pkg::mesi_w-1:0] state;
	logic [tag_w-1:0]            tag;
	logic [line_w-1:0]           line;

	// write side, driven by the controller
	logic                        wr_en;
	logic [cache_pkg::mesi_w-1:0] wr_state;
	logic [tag_w-1:0]            wr_tag;
	logic [line_w-1:0]           wr_line;

	modport store (output hit, state, tag, line,
		input wr_en, wr_state, wr_tag, wr_line);

	modport ctrl (output wr_en, wr_state, wr_tag, wr_line);

	modport view (input hit, state, tag, line);

endinterface

`default_nettype wire

// ==== design/cache_pkg.sv ====
// shared widths and MESI codes; addresses are byte addresses and CPU data is one byte
`default_nettype none

package cache_pkg;

	////////////////////////////////////////
	// bus widths

	localparam int addr_w = 32; // cpu and snoop address
	localparam int byte_w = 8;  // cpu read and write data

	////////////////////////////////////////
	// MESI state codes

	localparam int mesi_w = 2;

	localparam logic [mesi_w-1:0] st_i = 2'b00; // invalid
	localparam logic [mesi_w-1:0] st_s = 2'b01; // shared, clean
	localparam logic [mesi_w-1:0] st_e = 2'b10; // exclusive, clean
	localparam logic [mesi_w-1:0] st_m = 2'b11; // modified, owes a cast out

endpackage

`default_nettype wire
